/* project.f */
design/seg7_cfg_pkg.sv
design/seg7_bus_pkg.sv
design/seg7_regs.sv
design/scan_timer.sv
design/hex_glyph.sv
design/digit_mux.sv
design/seg7_display.sv
bench/seg7_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= seg7_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/10ps -Wno-fatal
PASS_TEXT ?= TEST PASSED

SIM := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* bench/seg7_tb.sv */
`default_nettype none
`timescale 1ns/10ps

module seg7_tb;

    localparam int strb_w      = seg7_bus_pkg::bus_data_w / 8;
    localparam int scan_period = 2 * seg7_cfg_pkg::scan_shifts * seg7_cfg_pkg::num_digits;
    localparam int wait_limit  = 200;             // Cycles before a handshake counts as stuck

    typedef logic [seg7_bus_pkg::addr_w-1:0]     addr_t;
    typedef logic [seg7_bus_pkg::bus_data_w-1:0] word_t;
    typedef logic [strb_w-1:0]                   strb_t;

    logic                                clk;
    logic                                rst;
    addr_t                               s_axi_awaddr;
    logic                                s_axi_awvalid;
    logic                                s_axi_awready;
    word_t                               s_axi_wdata;
    strb_t                               s_axi_wstrb;
    logic                                s_axi_wvalid;
    logic                                s_axi_wready;
    logic [1:0]                          s_axi_bresp;
    logic                                s_axi_bvalid;
    logic                                s_axi_bready;
    addr_t                               s_axi_araddr;
    logic                                s_axi_arvalid;
    logic                                s_axi_arready;
    word_t                               s_axi_rdata;
    logic [1:0]                          s_axi_rresp;
    logic                                s_axi_rvalid;
    logic                                s_axi_rready;
    logic [7:0]                          seg;
    logic [seg7_cfg_pkg::num_digits-1:0] an;

    logic [31:0]                         lfsr = 32'he01c034a;
    logic [seg7_cfg_pkg::data_w-1:0]     m_data;       // Display model registers
    logic [seg7_cfg_pkg::num_digits-1:0] m_dp;
    logic [seg7_cfg_pkg::num_digits-1:0] m_en;
    logic [seg7_cfg_pkg::num_digits-1:0] seen;         // Digits observed lit
    logic                                stalled = 1'b0;
    int                                  errors;
    int                                  checks;
    int                                  err_base;

    seg7_display u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // Taps 32 22 2 1
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r[i] = lfsr[0];
        end
        return r;
    endfunction

    function automatic logic is_mapped(input addr_t addr);
        return addr == seg7_bus_pkg::reg_data_off || addr == seg7_bus_pkg::reg_dp_off ||
               addr == seg7_bus_pkg::reg_en_off;
    endfunction

    function automatic logic [1:0] expect_resp(input addr_t addr);
        if (is_mapped(addr)) begin
            return seg7_bus_pkg::resp_okay;
        end
        return seg7_bus_pkg::resp_slverr;
    endfunction

    function automatic addr_t pick_reg();
        logic [1:0] k;
        k = 2'(rand_bits(2));
        if (k == 2'd1) begin
            return seg7_bus_pkg::reg_dp_off;
        end else if (k == 2'd2) begin
            return seg7_bus_pkg::reg_en_off;
        end
        return seg7_bus_pkg::reg_data_off;
    endfunction

    function automatic word_t model_read(input addr_t addr);
        if (addr == seg7_bus_pkg::reg_data_off) begin
            return word_t'(m_data);
        end else if (addr == seg7_bus_pkg::reg_dp_off) begin
            return word_t'(m_dp);
        end else if (addr == seg7_bus_pkg::reg_en_off) begin
            return word_t'(m_en);
        end
        return '0;                                  // Unmapped space reads as zero
    endfunction

    function automatic void model_write(input addr_t addr, input word_t wdata, input strb_t wstrb);
        word_t mask;
        word_t merged;
        mask = '0;
        for (int i = 0; i < strb_w; i++) begin
            mask[i*8 +: 8] = {8{wstrb[i]}};
        end
        merged = (model_read(addr) & ~mask) | (wdata & mask);
        if (addr == seg7_bus_pkg::reg_data_off) begin
            m_data = merged[seg7_cfg_pkg::data_w-1:0];
        end else if (addr == seg7_bus_pkg::reg_dp_off) begin
            m_dp = merged[seg7_cfg_pkg::num_digits-1:0];
        end else if (addr == seg7_bus_pkg::reg_en_off) begin
            m_en = merged[seg7_cfg_pkg::num_digits-1:0];
        end
    endfunction

    // Inverted glyph with the inverted dot on top
    function automatic logic [7:0] expected_seg(input int d);
        seg7_cfg_pkg::glyph_t g;
        g = seg7_cfg_pkg::glyph_table[m_data[d*4 +: 4]];
        return {~m_dp[d], ~g};
    endfunction

    task automatic report_error(input string msg);
        errors++;
        $display("** Error @ %0t: %s", $time, msg);
    endtask

    task automatic check_resp(input logic [1:0] got, input logic [1:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            report_error($sformatf("%s: resp %0d, expected %0d", what, got, exp));
        end
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        checks++;
        if (got !== exp) begin
            report_error($sformatf("%s: data 0x%08h, expected 0x%08h", what, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            report_error($sformatf("%s: %b, expected %b", what, got, exp));
        end
    endtask

    task automatic check_digit(input logic [7:0] seg_v,
                               input logic [seg7_cfg_pkg::num_digits-1:0] an_v,
                               input string what);
        int d;
        d = 0;
        checks++;
        if (an_v === '1) begin
            if (seg_v !== 8'hff) begin
                report_error($sformatf("%s: seg 0x%02h with no anode low", what, seg_v));
            end
        end else if ($countones(~an_v) != 1) begin
            report_error($sformatf("%s: an 0x%01h has more than one digit low", what, an_v));
        end else begin
            for (int i = 0; i < seg7_cfg_pkg::num_digits; i++) begin
                if (!an_v[i]) begin
                    d = i;
                end
            end
            seen[d] = 1'b1;
            if (!m_en[d]) begin
                report_error($sformatf("%s: digit %0d lit but disabled", what, d));
            end else if (seg_v !== expected_seg(d)) begin
                report_error($sformatf("%s: digit %0d seg 0x%02h, expected 0x%02h",
                                       what, d, seg_v, expected_seg(d)));
            end
        end
    endtask

    task automatic stall(input string what);
        $display("Timeout after %0d cycles: %s", wait_limit, what);
        stalled = 1'b1;
        wait (stalled == 1'b0);                     // Parked until the watchdog ends the run
    endtask

    // Ready is sampled on the falling edge and the beat lands on the next rising edge
    task automatic send_aw(input addr_t addr);
        int waited;
        waited = 0;
        @(posedge clk);
        s_axi_awaddr  <= addr;
        s_axi_awvalid <= 1'b1;
        @(negedge clk);
        while (!s_axi_awready) begin
            waited++;
            if (waited > wait_limit) begin
                stall("write address channel never became ready");
            end
            @(negedge clk);
        end
        @(posedge clk);
        s_axi_awvalid <= 1'b0;
    endtask

    task automatic send_w(input word_t wdata, input strb_t wstrb);
        int waited;
        waited = 0;
        @(posedge clk);
        s_axi_wdata  <= wdata;
        s_axi_wstrb  <= wstrb;
        s_axi_wvalid <= 1'b1;
        @(negedge clk);
        while (!s_axi_wready) begin
            waited++;
            if (waited > wait_limit) begin
                stall("write data channel never became ready");
            end
            @(negedge clk);
        end
        @(posedge clk);
        s_axi_wvalid <= 1'b0;
    endtask

    task automatic send_ar(input addr_t addr);
        int waited;
        waited = 0;
        @(posedge clk);
        s_axi_araddr  <= addr;
        s_axi_arvalid <= 1'b1;
        @(negedge clk);
        while (!s_axi_arready) begin
            waited++;
            if (waited > wait_limit) begin
                stall("read address channel never became ready");
            end
            @(negedge clk);
        end
        @(posedge clk);
        s_axi_arvalid <= 1'b0;
    endtask

    // Holds bready low for hold cycles once B is valid and then takes it
    task automatic take_b(input int hold, output logic [1:0] resp);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!s_axi_bvalid) begin
            waited++;
            if (waited > wait_limit) begin
                stall("no write response arrived");
            end
            @(negedge clk);
        end
        resp = s_axi_bresp;
        repeat (hold) begin
            @(negedge clk);
            check_flag(s_axi_bvalid, 1'b1, "bvalid under back-pressure");
            check_flag(s_axi_awready, 1'b0, "awready while B pending");
            check_flag(s_axi_wready, 1'b0, "wready while B pending");
            check_resp(s_axi_bresp, resp, "bresp under back-pressure");
        end
        @(posedge clk);
        s_axi_bready <= 1'b1;
        @(posedge clk);
        s_axi_bready <= 1'b0;
    endtask

    task automatic take_r(input int hold, output word_t rdata, output logic [1:0] resp);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!s_axi_rvalid) begin
            waited++;
            if (waited > wait_limit) begin
                stall("no read response arrived");
            end
            @(negedge clk);
        end
        rdata = s_axi_rdata;
        resp  = s_axi_rresp;
        repeat (hold) begin
            @(negedge clk);
            check_flag(s_axi_rvalid, 1'b1, "rvalid under back-pressure");
            check_flag(s_axi_arready, 1'b0, "arready while R pending");
            check_word(s_axi_rdata, rdata, "rdata under back-pressure");
            check_resp(s_axi_rresp, resp, "rresp under back-pressure");
        end
        @(posedge clk);
        s_axi_rready <= 1'b1;
        @(posedge clk);
        s_axi_rready <= 1'b0;
    endtask

    // Order 0 sends AW first and order 1 sends W first
    // Any other order sends both at once
    task automatic bus_write(input addr_t addr, input word_t wdata, input strb_t wstrb,
                             input int order);
        logic [1:0] resp;
        if (order == 0) begin
            send_aw(addr);
            send_w(wdata, wstrb);
        end else if (order == 1) begin
            send_w(wdata, wstrb);
            send_aw(addr);
        end else begin
            fork
                send_aw(addr);
                send_w(wdata, wstrb);
            join
        end
        take_b(0, resp);
        check_resp(resp, expect_resp(addr), $sformatf("write 0x%02h", addr));
        model_write(addr, wdata, wstrb);
    endtask

    task automatic bus_read(input addr_t addr);
        word_t      rdata;
        logic [1:0] resp;
        send_ar(addr);
        take_r(0, rdata, resp);
        check_resp(resp, expect_resp(addr), $sformatf("read 0x%02h", addr));
        check_word(rdata, model_read(addr), $sformatf("read 0x%02h", addr));
    endtask

    task automatic read_all();
        bus_read(seg7_bus_pkg::reg_data_off);
        bus_read(seg7_bus_pkg::reg_dp_off);
        bus_read(seg7_bus_pkg::reg_en_off);
    endtask

    task automatic watch_display(input int cycles, input string what);
        repeat (cycles) begin
            @(negedge clk);
            check_digit(seg, an, what);
        end
    endtask

    task automatic finish_test(input string name);
        $display("%s: %0d errors", name, errors - err_base);
        err_base = errors;
    endtask

    initial begin
        wait (stalled == 1'b1);
        $display("Stopped on a handshake timeout after %0d checks, %0d errors", checks, errors);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        addr_t      addr;
        addr_t      addr2;
        word_t      word;
        word_t      word2;
        logic [1:0] resp;
        int         hold;
        errors   = 0;
        checks   = 0;
        err_base = 0;
        m_data   = '0;
        m_dp     = '0;
        m_en     = '0;
        seen     = '0;
        rst           <= 1'b1;
        s_axi_awaddr  <= '0;
        s_axi_awvalid <= 1'b0;
        s_axi_wdata   <= '0;
        s_axi_wstrb   <= '0;
        s_axi_wvalid  <= 1'b0;
        s_axi_bready  <= 1'b0;
        s_axi_araddr  <= '0;
        s_axi_arvalid <= 1'b0;
        s_axi_rready  <= 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        watch_display(2 * scan_period, "after reset");   // All registers zero so every digit stays dark
        read_all();
        finish_test("1 reset state");

        repeat (24) begin
            addr = pick_reg();
            bus_write(addr, rand_bits(32), strb_t'(rand_bits(strb_w)), int'(rand_bits(2)));
            bus_read(addr);
        end
        finish_test("2 register writes");

        repeat (12) begin
            addr = addr_t'(rand_bits(seg7_bus_pkg::addr_w));
            if (is_mapped(addr)) begin
                addr = addr ^ addr_t'(1);
            end
            bus_write(addr, rand_bits(32), strb_t'(rand_bits(strb_w)), int'(rand_bits(2)));
            bus_read(addr);
            read_all();
        end
        finish_test("3 unmapped offsets");

        repeat (3) begin
            bus_write(seg7_bus_pkg::reg_data_off, rand_bits(32), '1, 2);
            bus_write(seg7_bus_pkg::reg_dp_off, rand_bits(32), '1, 2);
            bus_write(seg7_bus_pkg::reg_en_off, rand_bits(32), '1, 2);
            repeat (2 * scan_period) @(negedge clk);     // Let every digit pick up the values
            seen = '0;
            watch_display(4 * scan_period, "scan");
            if (seen !== m_en) begin
                report_error($sformatf("digits seen %b, enabled %b", seen, m_en));
            end
        end
        finish_test("4 display scan");

        repeat (4) begin
            addr  = pick_reg();
            addr2 = pick_reg();
            word  = rand_bits(32);
            word2 = rand_bits(32);
            hold  = int'(rand_bits(4)) + 1;
            fork
                send_aw(addr);
                send_w(word, '1);
            join
            fork
                send_aw(addr2);                              // Must wait for B
                take_b(hold, resp);
            join
            check_resp(resp, seg7_bus_pkg::resp_okay, "held write response");
            model_write(addr, word, '1);
            send_w(word2, '1);
            take_b(0, resp);
            check_resp(resp, seg7_bus_pkg::resp_okay, "queued write response");
            model_write(addr2, word2, '1);
            send_ar(addr);
            fork
                send_ar(addr2);                              // Must wait for R
                take_r(hold, word, resp);
            join
            check_resp(resp, seg7_bus_pkg::resp_okay, "held read response");
            check_word(word, model_read(addr), "held read data");
            take_r(0, word, resp);
            check_resp(resp, seg7_bus_pkg::resp_okay, "queued read response");
            check_word(word, model_read(addr2), "queued read data");
        end
        finish_test("5 back-pressure");

        $display("Done: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* design/seg7_display.sv */
`default_nettype none
`timescale 1ns/10ps

module seg7_display (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [seg7_bus_pkg::addr_w-1:0]       s_axi_awaddr,
    input  logic                                  s_axi_awvalid,
    output logic                                  s_axi_awready,
    input  logic [seg7_bus_pkg::bus_data_w-1:0]   s_axi_wdata,
    input  logic [seg7_bus_pkg::bus_data_w/8-1:0] s_axi_wstrb,
    input  logic                                  s_axi_wvalid,
    output logic                                  s_axi_wready,
    output logic [1:0]                            s_axi_bresp,
    output logic                                  s_axi_bvalid,
    input  logic                                  s_axi_bready,
    input  logic [seg7_bus_pkg::addr_w-1:0]       s_axi_araddr,
    input  logic                                  s_axi_arvalid,
    output logic                                  s_axi_arready,
    output logic [seg7_bus_pkg::bus_data_w-1:0]   s_axi_rdata,
    output logic [1:0]                            s_axi_rresp,
    output logic                                  s_axi_rvalid,
    input  logic                                  s_axi_rready,
    output logic [7:0]                            seg,
    output logic [seg7_cfg_pkg::num_digits-1:0]   an
);

    logic [seg7_cfg_pkg::data_w-1:0]      data;
    logic [seg7_cfg_pkg::num_digits-1:0]  dp_mask;
    logic [seg7_cfg_pkg::num_digits-1:0]  en_mask;
    logic                                 tick;
    logic [seg7_cfg_pkg::digit_idx_w-1:0] digit;
    logic [3:0]                           nibble;
    seg7_cfg_pkg::glyph_t                 glyph;

    seg7_regs u_regs (
        .clk           (clk),
        .rst           (rst),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wstrb   (s_axi_wstrb),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .data          (data),
        .dp_mask       (dp_mask),
        .en_mask       (en_mask)
    );

    scan_timer u_scan (
        .clk   (clk),
        .rst   (rst),
        .tick  (tick),
        .digit (digit)
    );

    hex_glyph u_glyph (
        .clk    (clk),
        .rst    (rst),
        .nibble (nibble),
        .glyph  (glyph)
    );

    digit_mux u_mux (
        .clk     (clk),
        .rst     (rst),
        .tick    (tick),
        .digit   (digit),
        .data    (data),
        .dp_mask (dp_mask),
        .en_mask (en_mask),
        .nibble  (nibble),
        .glyph   (glyph),
        .seg     (seg),
        .an      (an)
    );

endmodule

`default_nettype wire

/* design/digit_mux.sv */
`default_nettype none
`timescale 1ns/10ps

module digit_mux (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 tick,
    input  logic [seg7_cfg_pkg::digit_idx_w-1:0] digit,
    input  logic [seg7_cfg_pkg::data_w-1:0]      data,
    input  logic [seg7_cfg_pkg::num_digits-1:0]  dp_mask,
    input  logic [seg7_cfg_pkg::num_digits-1:0]  en_mask,
    output logic [3:0]                           nibble,
    input  seg7_cfg_pkg::glyph_t                 glyph,
    output logic [7:0]                           seg,
    output logic [seg7_cfg_pkg::num_digits-1:0]  an
);

    logic [seg7_cfg_pkg::digit_idx_w-1:0] sel_q;   // Digit being shown
    logic                                 en_q;
    logic                                 dot_q;
    logic                                 load_q;  // Nibble sent, glyph in flight
    logic                                 show_q;  // Glyph ready, update pins next

    // Selection sampled on tick, held for the whole scan slot
    always_ff @(posedge clk) begin
        if (tick) begin
            sel_q  <= digit;
            dot_q  <= dp_mask[digit];
            nibble <= data[digit*4 +: 4];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            en_q   <= 1'b0;
            load_q <= 1'b0;
            show_q <= 1'b0;
            seg    <= '1;                            // Active low, all dark
            an     <= '1;
        end else begin
            load_q <= tick;
            show_q <= load_q;
            if (tick) begin
                en_q <= en_mask[digit];
            end
            if (show_q) begin                        // seg and an move on the same edge
                if (en_q) begin
                    seg <= {~dot_q, ~glyph};
                    an  <= ~(seg7_cfg_pkg::num_digits'(1) << sel_q);
                end else begin
                    seg <= '1;                       // Blanked digit
                    an  <= '1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* design/hex_glyph.sv */
`default_nettype none
`timescale 1ns/10ps

module hex_glyph (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [3:0]           nibble,
    output seg7_cfg_pkg::glyph_t glyph
);

    // Clocked lookup, result appears one cycle after the nibble
    always_ff @(posedge clk) begin
        if (rst) begin
            glyph <= '0;                                    // All segments dark
        end else begin
            glyph <= seg7_cfg_pkg::glyph_table[nibble];
        end
    end

endmodule

`default_nettype wire

/* design/scan_timer.sv */
`default_nettype none
`timescale 1ns/10ps

module scan_timer #(
    parameter int stages = seg7_cfg_pkg::scan_shifts   // At least 2
) (
    input  logic                                 clk,
    input  logic                                 rst,
    output logic                                 tick,
    output logic [seg7_cfg_pkg::digit_idx_w-1:0] digit
);

    logic [stages-1:0] jc;     // Johnson ring, 2 x stages states
    logic              wrap;

    // Last state of the sequence, a single one in the top stage
    assign wrap = (jc == {1'b1, {(stages-1){1'b0}}});

    always_ff @(posedge clk) begin
        if (rst) begin
            jc    <= '0;
            tick  <= 1'b0;
            digit <= '0;
        end else begin
            jc   <= {jc[stages-2:0], ~jc[stages-1]};   // Twisted feedback
            tick <= wrap;                              // One cycle per full wrap
            if (wrap) begin
                digit <= digit + seg7_cfg_pkg::digit_idx_w'(1);   // Wraps modulo 4
            end
        end
    end

    // The digit index moves together with tick, so a consumer sampling
    // on tick already sees the new digit

endmodule

`default_nettype wire

/* design/seg7_regs.sv */
`default_nettype none
`timescale 1ns/10ps

module seg7_regs (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [seg7_bus_pkg::addr_w-1:0]       s_axi_awaddr,
    input  logic                                  s_axi_awvalid,
    output logic                                  s_axi_awready,
    input  logic [seg7_bus_pkg::bus_data_w-1:0]   s_axi_wdata,
    input  logic [seg7_bus_pkg::bus_data_w/8-1:0] s_axi_wstrb,
    input  logic                                  s_axi_wvalid,
    output logic                                  s_axi_wready,
    output logic [1:0]                            s_axi_bresp,
    output logic                                  s_axi_bvalid,
    input  logic                                  s_axi_bready,
    input  logic [seg7_bus_pkg::addr_w-1:0]       s_axi_araddr,
    input  logic                                  s_axi_arvalid,
    output logic                                  s_axi_arready,
    output logic [seg7_bus_pkg::bus_data_w-1:0]   s_axi_rdata,
    output logic [1:0]                            s_axi_rresp,
    output logic                                  s_axi_rvalid,
    input  logic                                  s_axi_rready,
    output logic [seg7_cfg_pkg::data_w-1:0]       data,
    output logic [seg7_cfg_pkg::num_digits-1:0]   dp_mask,
    output logic [seg7_cfg_pkg::num_digits-1:0]   en_mask
);

    logic                                  aw_full;   // Write address held
    logic                                  w_full;    // Write data held
    logic [seg7_bus_pkg::addr_w-1:0]       awaddr_q;
    logic [seg7_bus_pkg::bus_data_w-1:0]   wdata_q;
    logic [seg7_bus_pkg::bus_data_w/8-1:0] wstrb_q;
    logic                                  wr_go;     // Both halves present, no B pending
    logic                                  wr_hit;
    logic                                  rd_hit;
    logic [seg7_bus_pkg::bus_data_w-1:0]   rd_word;

    // Replace the byte lanes of cur that are selected by strb
    function automatic logic [seg7_bus_pkg::bus_data_w-1:0] merge_strb(
        input logic [seg7_bus_pkg::bus_data_w-1:0]   cur,
        input logic [seg7_bus_pkg::bus_data_w-1:0]   wr,
        input logic [seg7_bus_pkg::bus_data_w/8-1:0] strb
    );
        logic [seg7_bus_pkg::bus_data_w-1:0] res;
        res = cur;
        for (int i = 0; i < seg7_bus_pkg::bus_data_w / 8; i++) begin
            if (strb[i]) begin
                res[i*8 +: 8] = wr[i*8 +: 8];
            end
        end
        return res;
    endfunction

    assign s_axi_awready = ~aw_full;
    assign s_axi_wready  = ~w_full;
    assign s_axi_arready = ~s_axi_rvalid;     // One read in flight at most
    assign wr_go         = aw_full & w_full & ~s_axi_bvalid;

    assign wr_hit = (awaddr_q == seg7_bus_pkg::reg_data_off) ||
                    (awaddr_q == seg7_bus_pkg::reg_dp_off) ||
                    (awaddr_q == seg7_bus_pkg::reg_en_off);

    always_comb begin
        rd_hit  = 1'b1;
        rd_word = '0;
        case (s_axi_araddr)
            seg7_bus_pkg::reg_data_off: rd_word = seg7_bus_pkg::bus_data_w'(data);
            seg7_bus_pkg::reg_dp_off:   rd_word = seg7_bus_pkg::bus_data_w'(dp_mask);
            seg7_bus_pkg::reg_en_off:   rd_word = seg7_bus_pkg::bus_data_w'(en_mask);
            default:                    rd_hit  = 1'b0;   // Unmapped reads back as 0
        endcase
    end

    // Handshake state and the registers themselves
    always_ff @(posedge clk) begin
        if (rst) begin
            aw_full      <= 1'b0;
            w_full       <= 1'b0;
            s_axi_bvalid <= 1'b0;
            s_axi_rvalid <= 1'b0;
            data         <= '0;
            dp_mask      <= '0;
            en_mask      <= '0;
        end else begin
            if (s_axi_awvalid && !aw_full) begin
                aw_full <= 1'b1;
            end
            if (s_axi_wvalid && !w_full) begin
                w_full <= 1'b1;
            end
            if (wr_go) begin
                s_axi_bvalid <= 1'b1;
                case (awaddr_q)
                    seg7_bus_pkg::reg_data_off:
                        data <= seg7_cfg_pkg::data_w'(merge_strb(
                            seg7_bus_pkg::bus_data_w'(data), wdata_q, wstrb_q));
                    seg7_bus_pkg::reg_dp_off:
                        dp_mask <= seg7_cfg_pkg::num_digits'(merge_strb(
                            seg7_bus_pkg::bus_data_w'(dp_mask), wdata_q, wstrb_q));
                    seg7_bus_pkg::reg_en_off:
                        en_mask <= seg7_cfg_pkg::num_digits'(merge_strb(
                            seg7_bus_pkg::bus_data_w'(en_mask), wdata_q, wstrb_q));
                    default: ;                              // Nothing written
                endcase
            end
            if (s_axi_bvalid && s_axi_bready) begin
                s_axi_bvalid <= 1'b0;
                aw_full      <= 1'b0;                      // Reopen both channels
                w_full       <= 1'b0;
            end
            if (s_axi_arvalid && !s_axi_rvalid) begin
                s_axi_rvalid <= 1'b1;
            end else if (s_axi_rvalid && s_axi_rready) begin
                s_axi_rvalid <= 1'b0;
            end
        end
    end

    // Captured payloads and response words
    always_ff @(posedge clk) begin
        if (s_axi_awvalid && !aw_full) begin
            awaddr_q <= s_axi_awaddr;
        end
        if (s_axi_wvalid && !w_full) begin
            wdata_q <= s_axi_wdata;
            wstrb_q <= s_axi_wstrb;
        end
        if (wr_go) begin
            s_axi_bresp <= wr_hit ? seg7_bus_pkg::resp_okay : seg7_bus_pkg::resp_slverr;
        end
        if (s_axi_arvalid && !s_axi_rvalid) begin
            s_axi_rdata <= rd_word;
            s_axi_rresp <= rd_hit ? seg7_bus_pkg::resp_okay : seg7_bus_pkg::resp_slverr;
        end
    end

endmodule

`default_nettype wire

/* design/seg7_bus_pkg.sv */
`default_nettype none

package seg7_bus_pkg;

    localparam int addr_w     = 8;                 // AXI4-Lite address width
    localparam int bus_data_w = 32;                // AXI4-Lite data width

    // Register map
    localparam logic [addr_w-1:0] reg_data_off = 8'h10;   // Hex value, one nibble per digit
    localparam logic [addr_w-1:0] reg_dp_off   = 8'h14;   // Decimal point mask
    localparam logic [addr_w-1:0] reg_en_off   = 8'h18;   // Digit enable mask

    // Response codes on B and R
    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

endpackage

`default_nettype wire

/* design/seg7_cfg_pkg.sv */
`default_nettype none

package seg7_cfg_pkg;

    localparam int num_digits  = 4;                // Digits on the display
    localparam int digit_idx_w = 2;                // Enough to index num_digits
    localparam int data_w      = num_digits * 4;   // One hex nibble per digit
    localparam int scan_shifts = 10;               // Johnson stages, tick every 2x cycles

    // Segment pattern, bit 0 is segment a up to bit 6 for segment g, set means lit
    typedef logic [6:0] glyph_t;

    localparam glyph_t glyph_table [16] = '{
        7'h3f, 7'h06, 7'h5b, 7'h4f,                // 0 1 2 3
        7'h66, 7'h6d, 7'h7d, 7'h07,                // 4 5 6 7
        7'h7f, 7'h6f, 7'h77, 7'h7c,                // 8 9 A b
        7'h39, 7'h5e, 7'h79, 7'h71                 // C d E F
    };

endpackage

`default_nettype wire
